//--- compile.f
src/fu_types_pkg.sv
src/exec_flags_pkg.sv
src/complex_alu.sv
src/complex_fu_pipe.sv
src/hilo_regs.sv
src/complex_exec_top.sv
bench/tb_complex_exec.sv

//--- Bender.yml
package:
  name: complex_exec

sources:
  - files:
      - src/fu_types_pkg.sv
      - src/exec_flags_pkg.sv
      - src/complex_alu.sv
      - src/complex_fu_pipe.sv
      - src/hilo_regs.sv
      - src/complex_exec_top.sv

  - target: test
    files:
      - bench/tb_complex_exec.sv

//--- bench/tb_complex_exec.sv
// Random issue traffic from a fixed LCG seed; HI/LO and pending level are modelled here.
module tb_complex_exec;

  timeunit 1ns;
  timeprecision 100ps;

  import fu_types_pkg::*;
  import exec_flags_pkg::*;

  localparam int ISSUE_CYCLES   = 400;                            // cycles with random issue.
  localparam int TIMEOUT_CYCLES = ISSUE_CYCLES + PIPE_LATENCY + 20;

  logic    clk_i = 1'b0;         // 100 ns clock.
  logic    reset_i = 1'b1;       // held for the first four edges.
  logic    issue_valid_i = 1'b0;
  opcode_e opcode_i = MULT_L;
  data_t   data1_i = '0;
  data_t   data2_i = '0;
  tag_t    tag_i = '0;
  logic    exc_clear_i = 1'b0;
  logic    wb_valid_o;
  data_t   wb_result_o;
  tag_t    wb_tag_o;
  flags_t  wb_flags_o;
  data_t   hi_o;
  data_t   lo_o;
  logic    exception_pending_o;

  logic [31:0] lcg_state = 32'd69;  // generator state, fixed seed.
  int          cycle_count = 0;     // posedges seen, for the timeout.
  data_t       exp_result_q[$];     // expected results in issue order.
  tag_t        exp_tag_q[$];
  flags_t      exp_flags_q[$];
  int          exp_due_q[$];        // cycle at which each writeback must show.
  data_t       model_hi = '0;       // bench copy of the architectural HI.
  data_t       model_lo = '0;
  logic        model_pending = 1'b0;

  complex_exec_top DUT (.*);

  always #50 clk_i = ~clk_i;  // 50 ns half period.

  // #########################################################################
  // failure reporting and compare tasks
  // #########################################################################

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp_v, input data_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      stop_run();
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp_v, input tag_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      stop_run();
    end
  endtask

  task automatic check_flags(input string name, input flags_t exp_v, input flags_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
      stop_run();
    end
  endtask

  // #########################################################################
  // stimulus helpers and reference model
  // #########################################################################

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes constants.
    return lcg_state;
  endfunction

  function automatic data_t pick_operand();
    logic [31:0] r;
    r = lcg_next();
    if (r[31:29] != 3'b000) return lcg_next();  // seven in eight are plain random.
    case (r[28:27])
      2'd1:    return '1;                        // minus one.
      2'd2:    return {1'b1, {(DATA_W-1){1'b0}}};  // most negative value.
      default: return '0;                        // zero, hits divide by zero.
    endcase
  endfunction

  function automatic opcode_e pick_opcode();
    logic [31:0] r;
    logic [3:0]  code;
    r = lcg_next();
    code = 4'(r[27:0] % 9);                      // one of the nine legal codes.
    if (r[31:28] == 4'h0) code = 4'hf;           // now and then an unused code.
    return opcode_e'(code);
  endfunction

  function automatic data_t model_result(input opcode_e op, input data_t a, input data_t b);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    data_t           r;
    sa = longint'($signed(a));  // sign extended to 64 bits.
    sb = longint'($signed(b));
    ua = {32'b0, a};
    ub = {32'b0, b};
    r  = '0;
    // MIN / -1 is exact in 64 bits, so the low word is the dividend and the remainder is zero.
    case (op)
      MULT_L:  r = data_t'(sa * sb);
      MULT_H:  r = data_t'((sa * sb) >>> DATA_W);
      MULTU_L: r = data_t'(ua * ub);
      MULTU_H: r = data_t'((ua * ub) >> DATA_W);
      DIV_L:   r = (b == '0) ? '1 : data_t'(sa / sb);
      DIV_H:   r = (b == '0) ? a : data_t'(sa % sb);
      DIVU_L:  r = (b == '0) ? '1 : data_t'(ua / ub);
      DIVU_H:  r = (b == '0) ? a : data_t'(ua % ub);
      default: r = '0;                           // syscall and unused codes.
    endcase
    return r;
  endfunction

  function automatic flags_t model_flags(input opcode_e op, input data_t b);
    flags_t f;
    f = '0;
    case (op)
      MULT_L, MULTU_L, DIV_L, DIVU_L: f[FLAG_WRITES_LO] = 1'b1;
      MULT_H, MULTU_H, DIV_H, DIVU_H: f[FLAG_WRITES_HI] = 1'b1;
      SYSCALL:                        f[FLAG_EXCEPTION] = 1'b1;
      default: ;
    endcase
    if (op inside {MULT_L, MULT_H, MULTU_L, MULTU_H, DIV_L, DIV_H, DIVU_L, DIVU_H, SYSCALL})
      f[FLAG_EXECUTED] = 1'b1;                   // every legal code.
    if (op inside {DIV_L, DIV_H, DIVU_L, DIVU_H} && b == '0)
      f[FLAG_EXCEPTION] = 1'b1;                  // divide by zero traps.
    return f;
  endfunction

  // #########################################################################
  // timeout and main sequence
  // #########################################################################

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish", cycle_count);
      stop_run();
    end
  end

  initial begin
    logic        exp_valid;
    logic        exc_now;
    logic [31:0] r;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
    for (int cyc = 0; cyc < ISSUE_CYCLES + PIPE_LATENCY + 1; cyc++) begin
      @(negedge clk_i);                          // outputs settled since the last posedge.
      check_data("hi_o", model_hi, hi_o);
      check_data("lo_o", model_lo, lo_o);
      check_bit("exception_pending_o", model_pending, exception_pending_o);
      if (wb_valid_o && exp_due_q.size() == 0) begin
        $display("writeback at %0t ns with no operation in flight", $time);
        stop_run();
      end
      exp_valid = (exp_due_q.size() != 0) && (exp_due_q[0] == cyc);
      check_bit("wb_valid_o", exp_valid, wb_valid_o);
      exc_now = 1'b0;
      if (wb_valid_o) begin
        check_data("wb_result_o", exp_result_q[0], wb_result_o);
        check_tag("wb_tag_o", exp_tag_q[0], wb_tag_o);
        check_flags("wb_flags_o", exp_flags_q[0], wb_flags_o);
        if (exp_flags_q[0][FLAG_WRITES_HI]) model_hi = exp_result_q[0];  // lands next edge.
        if (exp_flags_q[0][FLAG_WRITES_LO]) model_lo = exp_result_q[0];
        exc_now = exp_flags_q[0][FLAG_EXCEPTION];
        void'(exp_result_q.pop_front());
        void'(exp_tag_q.pop_front());
        void'(exp_flags_q.pop_front());
        void'(exp_due_q.pop_front());
      end
      issue_valid_i = 1'b0;
      exc_clear_i   = 1'b0;
      if (cyc < ISSUE_CYCLES) begin
        r = lcg_next();
        issue_valid_i = (r[31:30] != 2'b00);     // about three issues in four cycles.
        exc_clear_i   = (r[29:26] == 4'h0);      // occasional clear from the handler.
        opcode_i      = pick_opcode();
        data1_i       = pick_operand();
        data2_i       = pick_operand();
        tag_i         = tag_t'(lcg_next() >> 25);
        if (r[25:22] == 4'h0) begin              // now and then a signed MIN / -1 divide.
          opcode_i = r[21] ? DIV_H : DIV_L;
          data1_i  = {1'b1, {(DATA_W-1){1'b0}}};
          data2_i  = '1;
        end
        if (issue_valid_i) begin
          exp_result_q.push_back(model_result(opcode_i, data1_i, data2_i));
          exp_tag_q.push_back(tag_i);
          exp_flags_q.push_back(model_flags(opcode_i, data2_i));
          exp_due_q.push_back(cyc + PIPE_LATENCY);
        end
      end
      if (exc_now) model_pending = 1'b1;         // a set beats a clear in the same cycle.
      else if (exc_clear_i) model_pending = 1'b0;
    end
    if (exp_due_q.size() != 0) begin
      $display("%0d operations never reached writeback", exp_due_q.size());
      stop_run();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- src/complex_exec_top.sv
// Issue to writeback is two cycles and issue to HI/LO is three; writeback never stalls.
module complex_exec_top (
  input  logic                   clk_i,                // lane clock.
  input  logic                   reset_i,              // synchronous, active high.
  input  logic                   issue_valid_i,        // one-cycle issue strobe.
  input  fu_types_pkg::opcode_e  opcode_i,             // issued operation.
  input  fu_types_pkg::data_t    data1_i,              // first source operand.
  input  fu_types_pkg::data_t    data2_i,              // second source operand.
  input  fu_types_pkg::tag_t     tag_i,                // destination tag.
  input  logic                   exc_clear_i,          // clears the pending exception.
  output logic                   wb_valid_o,           // one-cycle writeback strobe.
  output fu_types_pkg::data_t    wb_result_o,          // writeback result word.
  output fu_types_pkg::tag_t     wb_tag_o,             // writeback tag.
  output exec_flags_pkg::flags_t wb_flags_o,           // writeback flags.
  output fu_types_pkg::data_t    hi_o,                 // architectural HI.
  output fu_types_pkg::data_t    lo_o,                 // architectural LO.
  output logic                   exception_pending_o   // sticky exception level.
);

  complex_fu_pipe u_complex_fu_pipe (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .issue_valid_i (issue_valid_i),
    .opcode_i      (opcode_i),
    .data1_i       (data1_i),
    .data2_i       (data2_i),
    .tag_i         (tag_i),
    .wb_valid_o    (wb_valid_o),   // also feeds the HI/LO unit below.
    .wb_result_o   (wb_result_o),
    .wb_tag_o      (wb_tag_o),
    .wb_flags_o    (wb_flags_o)
  );

  hilo_regs u_hilo_regs (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .wb_valid_i          (wb_valid_o),   // same writeback the core sees.
    .wb_result_i         (wb_result_o),
    .wb_flags_i          (wb_flags_o),
    .exc_clear_i         (exc_clear_i),
    .hi_o                (hi_o),
    .lo_o                (lo_o),
    .exception_pending_o (exception_pending_o)
  );

endmodule

//--- src/hilo_regs.sv
// HI and LO update one cycle after writeback; a set of the exception level beats a clear.
module hilo_regs (
  input  logic                   clk_i,                // lane clock.
  input  logic                   reset_i,              // synchronous, active high.
  input  logic                   wb_valid_i,           // writeback strobe from the pipe.
  input  fu_types_pkg::data_t    wb_result_i,          // writeback result word.
  input  exec_flags_pkg::flags_t wb_flags_i,           // writeback flags.
  input  logic                   exc_clear_i,          // clears the pending exception.
  output fu_types_pkg::data_t    hi_o,                 // architectural HI.
  output fu_types_pkg::data_t    lo_o,                 // architectural LO.
  output logic                   exception_pending_o   // sticky exception level.
);

  import exec_flags_pkg::*;

  logic wr_hi;   // this writeback targets HI.
  logic wr_lo;   // this writeback targets LO.
  logic exc_set; // this writeback carries an exception.

  assign wr_hi   = wb_valid_i && wb_flags_i[FLAG_WRITES_HI];  // _H operations only.
  assign wr_lo   = wb_valid_i && wb_flags_i[FLAG_WRITES_LO];  // _L operations only.
  assign exc_set = wb_valid_i && wb_flags_i[FLAG_EXCEPTION];  // syscall or divide by zero.

  // #########################################################################
  // architectural HI and LO
  // #########################################################################

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hi_o <= '0;  // both words read as zero after reset.
      lo_o <= '0;
    end else begin
      if (wr_hi) begin
        hi_o <= wb_result_i;  // high half or remainder.
      end
      if (wr_lo) begin
        lo_o <= wb_result_i;  // low half or quotient.
      end
    end
  end

  // #########################################################################
  // sticky exception level
  // #########################################################################

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exception_pending_o <= 1'b0;  // no trap pending out of reset.
    end else if (exc_set) begin
      exception_pending_o <= 1'b1;  // checked first, so a new trap is never lost.
    end else if (exc_clear_i) begin
      exception_pending_o <= 1'b0;  // handler has taken the trap.
    end
  end

endmodule

//--- src/complex_fu_pipe.sv
// No back-pressure exists; every issue is accepted and retires exactly two cycles later.
module complex_fu_pipe (
  input  logic                   clk_i,          // lane clock.
  input  logic                   reset_i,        // synchronous, active high.
  input  logic                   issue_valid_i,  // one-cycle issue strobe.
  input  fu_types_pkg::opcode_e  opcode_i,       // issued operation.
  input  fu_types_pkg::data_t    data1_i,        // first source operand.
  input  fu_types_pkg::data_t    data2_i,        // second source operand.
  input  fu_types_pkg::tag_t     tag_i,          // destination tag.
  output logic                   wb_valid_o,     // one-cycle writeback strobe.
  output fu_types_pkg::data_t    wb_result_o,    // result word.
  output fu_types_pkg::tag_t     wb_tag_o,       // tag of the retiring operation.
  output exec_flags_pkg::flags_t wb_flags_o      // flags of the retiring operation.
);

  import fu_types_pkg::*;
  import exec_flags_pkg::*;

  logic    s1_valid;    // stage one holds a live operation.
  opcode_e s1_opcode;   // latched opcode.
  data_t   s1_data1;    // latched first operand.
  data_t   s1_data2;    // latched second operand.
  tag_t    s1_tag;      // latched destination tag.
  data_t   alu_result;  // ALU output for the stage one operation.
  flags_t  alu_flags;   // ALU flags for the stage one operation.

  // #########################################################################
  // stage one, issue latch
  // #########################################################################

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid <= 1'b0;  // pipe starts empty.
    end else begin
      s1_valid <= issue_valid_i;  // a new operation may enter every cycle.
    end
  end

  always_ff @(posedge clk_i) begin
    s1_opcode <= opcode_i;  // payload loads every cycle, the valid bit decides.
    s1_data1  <= data1_i;
    s1_data2  <= data2_i;
    s1_tag    <= tag_i;
  end

  complex_alu u_complex_alu (
    .data1_i  (s1_data1),
    .data2_i  (s1_data2),
    .opcode_i (s1_opcode),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  // #########################################################################
  // stage two, result register
  // #########################################################################

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_o <= 1'b0;  // no writeback straight out of reset.
    end else begin
      wb_valid_o <= s1_valid;  // follows the issue strobe by two edges.
    end
  end

  always_ff @(posedge clk_i) begin
    wb_result_o <= alu_result;  // result word.
    wb_tag_o    <= s1_tag;      // tag travels alongside the data.
    wb_flags_o  <= alu_flags;   // flags for the HI/LO unit and the core.
  end

endmodule

//--- src/complex_alu.sv
// Purely combinational single-cycle multiply and divide; timing closure is up to the user.
module complex_alu (
  input  fu_types_pkg::data_t    data1_i,   // multiplicand or dividend.
  input  fu_types_pkg::data_t    data2_i,   // multiplier or divisor.
  input  fu_types_pkg::opcode_e  opcode_i,  // operation to perform.
  output fu_types_pkg::data_t    result_o,  // the selected word of the result.
  output exec_flags_pkg::flags_t flags_o    // execution flags for writeback.
);

  import fu_types_pkg::*;
  import exec_flags_pkg::*;

  dword_t prod_s;     // full signed product.
  dword_t prod_u;     // full unsigned product.
  logic   div_zero;   // divisor is zero.
  logic   div_ovf;    // most negative value over minus one.
  data_t  den_s;      // divisor actually fed to the signed divider.
  data_t  den_u;      // divisor actually fed to the unsigned divider.
  data_t  quot_s;     // signed quotient.
  data_t  rem_s;      // signed remainder.
  data_t  quot_u;     // unsigned quotient.
  data_t  rem_u;      // unsigned remainder.

  // #########################################################################
  // multiplier
  // #########################################################################

  // The low 2*DATA_W bits of a product do not depend on signedness once the
  // operands are extended to full width, so one multiply shape serves both.
  assign prod_s = {{DATA_W{data1_i[DATA_W-1]}}, data1_i} *
                  {{DATA_W{data2_i[DATA_W-1]}}, data2_i};  // sign extended operands.
  assign prod_u = {{DATA_W{1'b0}}, data1_i} * {{DATA_W{1'b0}}, data2_i};  // zero extended.

  // #########################################################################
  // divider
  // #########################################################################

  assign div_zero = (data2_i == '0);                                // no divisor at all.
  assign div_ovf  = (data1_i == DATA_MIN) && (data2_i == DATA_ONES);  // quotient overflows.

  // Dividing the dividend by one gives exactly the overflow result of the dividend
  // and a zero remainder, so the overflow case needs no extra result mux.
  assign den_s = (div_zero || div_ovf) ? DATA_ONE : data2_i;  // keeps the divider defined.
  assign den_u = div_zero ? DATA_ONE : data2_i;               // zero case is patched below.

  assign quot_s = data_t'($signed(data1_i) / $signed(den_s));  // truncates toward zero.
  assign rem_s  = data_t'($signed(data1_i) % $signed(den_s));  // takes the dividend's sign.
  assign quot_u = data1_i / den_u;                             // plain unsigned quotient.
  assign rem_u  = data1_i % den_u;                             // plain unsigned remainder.

  // #########################################################################
  // result and flag select
  // #########################################################################

  always_comb begin
    result_o = '0;          // default for illegal opcodes.
    flags_o  = FLAGS_NONE;  // no flag on an illegal opcode.
    unique case (opcode_i)
      MULT_L: begin
        result_o = prod_s[DATA_W-1:0];  // low word of the signed product.
        flags_o  = FLAGS_LO;
      end
      MULT_H: begin
        result_o = prod_s[2*DATA_W-1:DATA_W];  // high word of the signed product.
        flags_o  = FLAGS_HI;
      end
      MULTU_L: begin
        result_o = prod_u[DATA_W-1:0];  // low word of the unsigned product.
        flags_o  = FLAGS_LO;
      end
      MULTU_H: begin
        result_o = prod_u[2*DATA_W-1:DATA_W];  // high word of the unsigned product.
        flags_o  = FLAGS_HI;
      end
      DIV_L, DIVU_L: begin
        result_o = (opcode_i == DIV_L) ? quot_s : quot_u;  // pick the signed or unsigned path.
        flags_o  = FLAGS_LO;
        if (div_zero) begin
          result_o = DATA_ONES;             // all ones quotient on a zero divisor.
          flags_o  = FLAGS_LO | FLAGS_EXC;  // and the trap is signalled.
        end
      end
      DIV_H, DIVU_H: begin
        result_o = (opcode_i == DIV_H) ? rem_s : rem_u;  // remainder of the chosen path.
        flags_o  = FLAGS_HI;
        if (div_zero) begin
          result_o = data1_i;               // remainder equals the dividend.
          flags_o  = FLAGS_HI | FLAGS_EXC;  // the divide by zero still traps.
        end
      end
      SYSCALL: begin
        result_o = '0;             // nothing is written back.
        flags_o  = FLAGS_SYSCALL;  // executed plus exception.
      end
      default: begin
        result_o = '0;          // unknown code acts as a no-op.
        flags_o  = FLAGS_NONE;
      end
    endcase
  end

endmodule

//--- src/exec_flags_pkg.sv
// Flag bit positions are shared with the rest of the core; bit 5 must stay zero.
package exec_flags_pkg;

  // #########################################################################
  // flag vector layout
  // #########################################################################

  localparam int FLAGS_W = 6;  // width of the execution flag vector.

  typedef logic [FLAGS_W-1:0] flags_t;  // flags travelling with each result.

  localparam int FLAG_MISPREDICT = 0;  // branch redirect, never raised here.
  localparam int FLAG_EXCEPTION  = 1;  // syscall or divide by zero.
  localparam int FLAG_WRITES_LO  = 2;  // result goes to LO.
  localparam int FLAG_EXECUTED   = 3;  // a legal opcode was executed.
  localparam int FLAG_WRITES_HI  = 4;  // result goes to HI.

  // #########################################################################
  // flag patterns per operation class
  // #########################################################################

  localparam flags_t FLAGS_NONE = '0;  // illegal opcode, nothing happened.

  localparam flags_t FLAGS_LO =
    flags_t'((1 << FLAG_EXECUTED) | (1 << FLAG_WRITES_LO));  // every _L operation.

  localparam flags_t FLAGS_HI =
    flags_t'((1 << FLAG_EXECUTED) | (1 << FLAG_WRITES_HI));  // every _H operation.

  localparam flags_t FLAGS_SYSCALL =
    flags_t'((1 << FLAG_EXECUTED) | (1 << FLAG_EXCEPTION));  // trap without a result.

  localparam flags_t FLAGS_EXC = flags_t'(1 << FLAG_EXCEPTION);  // added on divide by zero.

endpackage

//--- src/fu_types_pkg.sv
// DATA_W and TAG_W are fixed for the lane, and opcodes outside the nine listed act as no-ops.
package fu_types_pkg;

  // #########################################################################
  // widths and latency
  // #########################################################################

  localparam int DATA_W       = 32;  // one architectural word per operand.
  localparam int TAG_W        = 7;   // physical destination tag, 128 entries.
  localparam int PIPE_LATENCY = 2;   // issue latch plus result register.

  // #########################################################################
  // vector types
  // #########################################################################

  typedef logic [DATA_W-1:0]   data_t;   // one operand or one result word.
  typedef logic [2*DATA_W-1:0] dword_t;  // full product before a half is picked.
  typedef logic [TAG_W-1:0]    tag_t;    // destination tag carried to writeback.

  // Constants for the divide corner cases.
  localparam data_t DATA_MIN  = {1'b1, {(DATA_W-1){1'b0}}};  // most negative signed word.
  localparam data_t DATA_ONES = {DATA_W{1'b1}};              // all ones, also minus one.
  localparam data_t DATA_ONE  = data_t'(1);                  // harmless divisor.

  // #########################################################################
  // opcodes
  // #########################################################################

  typedef enum logic [3:0] {
    MULT_L  = 4'h0,  // signed product, low word.
    MULT_H  = 4'h1,  // signed product, high word.
    MULTU_L = 4'h2,  // unsigned product, low word.
    MULTU_H = 4'h3,  // unsigned product, high word.
    DIV_L   = 4'h4,  // signed quotient.
    DIV_H   = 4'h5,  // signed remainder.
    DIVU_L  = 4'h6,  // unsigned quotient.
    DIVU_H  = 4'h7,  // unsigned remainder.
    SYSCALL = 4'h8   // raises the exception flag and nothing else.
  } opcode_e;

  // Codes 4'h9 to 4'hf are left unnamed on purpose.

endpackage
